// File: memorySubsystem.f
common/memPkg.sv
design/readSelector.sv
design/writeBuffer.sv
arbiter/memRequestArbiter.sv
design/wordMemory.sv
design/memorySubsystem.sv
sim/clockGen.sv
sim/memorySubsystemTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module memorySubsystemTb \
	-f memorySubsystem.f --Mdir obj_dir -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1

// File: sim/memorySubsystemTb.sv
module memorySubsystemTb;
	import memPkg::*;

	localparam int NUM_CACHES = 4;
	localparam int WRITE_DEPTH = 4;
	localparam int READ_LATENCY = 2;

	// test sizes that also set the watchdog length
	localparam int FIRST_WRITES = 32;
	localparam int RR_ROUNDS = 3;
	localparam int RR_SIZE = 8;
	localparam int BP_WRITES = 12;
	localparam int MIX_BURSTS = 6;
	localparam int MIX_WRITES = 40;
	localparam int BURST_WORDS = FIRST_WRITES + 84 + RR_ROUNDS * NUM_CACHES * RR_SIZE
		+ 64 + BP_WRITES + NUM_CACHES * MIX_BURSTS * 64;
	localparam int TOTAL_WRITES = MEM_WORDS + BP_WRITES + MIX_WRITES;
	localparam int WATCH_CYCLES = (BURST_WORDS + TOTAL_WRITES) * 8 + 2000;

	logic clk;
	logic rst;
	logic [NUM_CACHES-1:0] readReq;
	memAddr_t [NUM_CACHES-1:0] readAddr;
	burstLen_t [NUM_CACHES-1:0] readSize;
	logic writeReq;
	memAddr_t writeAddr;
	memData_t writeData;
	logic [NUM_CACHES-1:0] readValid;
	memData_t readData;
	logic [NUM_CACHES-1:0] doneRead;
	logic writeReady;
	logic doneWrite;

	// model memory updated when the buffer accepts a write
	memData_t model [memAddr_t];
	memData_t expQ [NUM_CACHES][$];

	int errors = 0;
	int wordsChecked = 0;
	int requests = 0;
	int doneReads = 0;
	int acceptCount = 0;
	int doneWrites = 0;

	// pointer model for the round-robin phase
	int rrPtr = 0;
	logic rrCheck = 1'b0;

	logic bpCheck = 1'b0;
	logic bpSeen = 1'b0;
	int bpBase = 0;

	clockGen #(
		.PERIOD(20),
		.RESET_CYCLES(10)
	) clockGen0 (
		.clk(clk),
		.rst(rst)
	);

	memorySubsystem #(
		.NUM_CACHES(NUM_CACHES),
		.WRITE_DEPTH(WRITE_DEPTH),
		.READ_LATENCY(READ_LATENCY)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.readReq(readReq),
		.readAddr(readAddr),
		.readSize(readSize),
		.writeReq(writeReq),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.readValid(readValid),
		.readData(readData),
		.doneRead(doneRead),
		.writeReady(writeReady),
		.doneWrite(doneWrite)
	);

	function automatic memData_t expectedWord(input memAddr_t addr);
		if (model.exists(addr)) begin
			return model[addr];
		end
		return '0;
	endfunction

	// starts and ends at drive time
	task automatic writeWord(input memAddr_t addr, input memData_t data);
		writeReq = 1'b1;
		writeAddr = addr;
		writeData = data;
		@(negedge clk);
		while (!writeReady) @(negedge clk);
		@(posedge clk);
		#2;
		writeReq = 1'b0;
	endtask

	task automatic waitWrites();
		@(posedge clk);
		while (doneWrites != acceptCount) @(posedge clk);
		#2;
	endtask

	// expected words follow the address upward and wrap at the top
	task automatic readBurst(input int c, input memAddr_t addr, input burstLen_t size);
		int n;
		memAddr_t a;
		n = (size == '0) ? 64 : int'(size);
		a = addr;
		for (int k = 0; k < n; k++) begin
			expQ[c].push_back(expectedWord(a));
			a = a + memAddr_t'(1);
		end
		readAddr[c] = addr;
		readSize[c] = size;
		readReq[c] = 1'b1;
		requests++;
		@(negedge clk);
		while (!doneRead[c]) @(negedge clk);
		@(posedge clk);
		#2;
		readReq[c] = 1'b0;
		// one idle cycle before this cache may ask again
		@(posedge clk);
		#2;
	endtask

	// back-to-back bursts from one cache
	task automatic roundRobinBursts(input int c);
		for (int r = 0; r < RR_ROUNDS; r++) begin
			readBurst(c, memAddr_t'(64 * r + 16 * c), burstLen_t'(RR_SIZE));
		end
	endtask

	// reads stay in the lower half while writes fill the upper half
	task automatic cacheTraffic(input int c);
		for (int k = 0; k < MIX_BURSTS; k++) begin
			repeat ($urandom % 4) begin
				@(posedge clk);
				#2;
			end
			readBurst(c, memAddr_t'($urandom % 448), burstLen_t'($urandom));
		end
	endtask

	task automatic writeTraffic();
		for (int k = 0; k < MIX_WRITES; k++) begin
			repeat ($urandom % 6) begin
				@(posedge clk);
				#2;
			end
			writeWord({1'b1, 9'($urandom)}, $urandom);
		end
	endtask

	// comparer samples at the falling edge where outputs are settled
	always @(negedge clk) begin
		memData_t expWord;
		int pick;
		if (!rst) begin
			if ($countones(readValid) > 1) begin
				errors++;
				$display("error readValid: %h has more than one bit set", readValid);
			end
			for (int i = 0; i < NUM_CACHES; i++) begin
				if (readValid[i]) begin
					if (expQ[i].size() == 0) begin
						errors++;
						$display("cache %0d received a word it never asked for", i);
					end else begin
						expWord = expQ[i].pop_front();
						wordsChecked++;
						if (readData !== expWord) begin
							errors++;
							$display("error readData cache %0d: got %h, expected %h",
								i, readData, expWord);
						end
						if (doneRead[i] !== (expQ[i].size() == 0)) begin
							errors++;
							$display("error doneRead[%0d]: got %h, expected %h",
								i, doneRead[i], expQ[i].size() == 0);
						end
					end
				end else if (doneRead[i]) begin
					errors++;
					$display("cache %0d saw doneRead without a data word", i);
				end
				if (doneRead[i]) begin
					doneReads++;
					if (rrCheck) begin
						// first requester at or after the modeled pointer
						pick = -1;
						for (int k = NUM_CACHES - 1; k >= 0; k--) begin
							if (readReq[(rrPtr + k) % NUM_CACHES]) begin
								pick = (rrPtr + k) % NUM_CACHES;
							end
						end
						if (pick != i) begin
							errors++;
							$display("cache %0d finished out of turn, cache %0d was due", i, pick);
						end
					end
					rrPtr = (i + 1) % NUM_CACHES;
				end
			end
			if (writeReq && writeReady) begin
				model[writeAddr] = writeData;
				acceptCount++;
			end
			if (doneWrite) begin
				doneWrites++;
				if (doneWrites > acceptCount) begin
					errors++;
					$display("doneWrite pulsed with no accepted write left to commit");
				end
			end
			if (bpCheck && !bpSeen && writeReq && !writeReady) begin
				bpSeen = 1'b1;
				if (acceptCount - bpBase != WRITE_DEPTH) begin
					errors++;
					$display("buffer filled after %0d writes instead of %0d",
						acceptCount - bpBase, WRITE_DEPTH);
				end
			end
		end
	end

	initial begin
		void'($urandom(60192));
		readReq = '0;
		readAddr = '0;
		readSize = '0;
		writeReq = 1'b0;
		writeAddr = '0;
		writeData = '0;

		@(negedge rst);
		@(negedge clk);
		if (readValid !== '0 || doneRead !== '0) begin
			errors++;
			$display("error readValid/doneRead after reset: %h/%h, expected 0/0",
				readValid, doneRead);
		end
		if (doneWrite !== 1'b0 || writeReady !== 1'b1) begin
			errors++;
			$display("error doneWrite/writeReady after reset: %h/%h, expected 0/1",
				doneWrite, writeReady);
		end
		@(posedge clk);
		#2;

		// write then read back with one write committed at a time
		for (int k = 0; k < FIRST_WRITES; k++) begin
			writeWord(memAddr_t'(k), $urandom);
			waitWrites();
		end
		for (int c = 0; c < NUM_CACHES; c++) begin
			readBurst(c, memAddr_t'(8 * c), burstLen_t'(8));
		end

		// fill the rest so every later read has a known word
		for (int k = FIRST_WRITES; k < MEM_WORDS; k++) begin
			writeWord(memAddr_t'(k), $urandom);
		end
		waitWrites();

		// the last three bursts wrap past the top
		readBurst(0, memAddr_t'(5), burstLen_t'(1));
		readBurst(1, memAddr_t'(1023), burstLen_t'(2));
		readBurst(2, memAddr_t'(1015), burstLen_t'(17));
		readBurst(3, memAddr_t'(1000), burstLen_t'(0));

		// every cache asks again right away and the pointer sets the order
		rrCheck = 1'b1;
		fork
			roundRobinBursts(0);
			roundRobinBursts(1);
			roundRobinBursts(2);
			roundRobinBursts(3);
		join
		rrCheck = 1'b0;

		// writer keeps going while a long burst holds the arbiter
		fork
			readBurst(0, memAddr_t'(64), burstLen_t'(0));
			begin
				@(negedge clk);
				while (!readValid[0]) @(negedge clk);
				@(posedge clk);
				#2;
				bpBase = acceptCount;
				bpCheck = 1'b1;
				for (int k = 0; k < BP_WRITES; k++) begin
					writeWord(memAddr_t'(512 + k), $urandom);
				end
			end
		join
		bpCheck = 1'b0;
		if (!bpSeen) begin
			errors++;
			$display("writeReady never dropped while the burst held the arbiter");
		end
		waitWrites();
		readBurst(1, memAddr_t'(512), burstLen_t'(BP_WRITES));

		fork
			cacheTraffic(0);
			cacheTraffic(1);
			cacheTraffic(2);
			cacheTraffic(3);
			writeTraffic();
		join
		waitWrites();

		if (doneReads != requests) begin
			errors++;
			$display("%0d read requests ended with %0d doneRead pulses", requests, doneReads);
		end
		for (int c = 0; c < NUM_CACHES; c++) begin
			if (expQ[c].size() != 0) begin
				errors++;
				$display("cache %0d is still missing %0d words", c, expQ[c].size());
			end
		end

		$display("errors %0d, words checked %0d, bursts %0d, writes %0d",
			errors, wordsChecked, doneReads, doneWrites);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles with the tests still running", WATCH_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule : memorySubsystemTb

// File: sim/clockGen.sv
module clockGen #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release lines up with the stimulus drive time
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
	end

endmodule : clockGen

// File: design/memorySubsystem.sv
module memorySubsystem #(
	parameter int NUM_CACHES = 4,
	parameter int WRITE_DEPTH = 4,
	parameter int READ_LATENCY = 2
) (
	input  logic clk,
	input  logic rst,
	input  logic [NUM_CACHES-1:0] readReq,
	input  memPkg::memAddr_t [NUM_CACHES-1:0] readAddr,
	input  memPkg::burstLen_t [NUM_CACHES-1:0] readSize,
	input  logic writeReq,
	input  memPkg::memAddr_t writeAddr,
	input  memPkg::memData_t writeData,
	output logic [NUM_CACHES-1:0] readValid,
	output memPkg::memData_t readData,
	output logic [NUM_CACHES-1:0] doneRead,
	output logic writeReady,
	output logic doneWrite
);
	import memPkg::*;

	// selector to arbiter
	logic grantValid;
	logic grantTaken;
	logic [$clog2(NUM_CACHES)-1:0] grantCache;
	memAddr_t grantAddr;
	burstLen_t grantSize;

	// write buffer head
	logic wrPending;
	logic wrPop;
	memAddr_t wrAddr;
	memData_t wrData;

	// memory port
	memAddr_t memAddr;
	memData_t memWdata;
	memData_t memRdata;
	logic memWrite;
	logic memRead;
	logic memRvalid;

	readSelector #(
		.NUM_CACHES(NUM_CACHES)
	) selector0 (
		.clk(clk),
		.rst(rst),
		.readReq(readReq),
		.readAddr(readAddr),
		.readSize(readSize),
		.grantTaken(grantTaken),
		.grantValid(grantValid),
		.grantCache(grantCache),
		.grantAddr(grantAddr),
		.grantSize(grantSize)
	);

	writeBuffer #(
		.WRITE_DEPTH(WRITE_DEPTH)
	) buffer0 (
		.clk(clk),
		.rst(rst),
		.writeReq(writeReq),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.wrPop(wrPop),
		.writeReady(writeReady),
		.wrPending(wrPending),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	memRequestArbiter #(
		.NUM_CACHES(NUM_CACHES)
	) arbiter0 (
		.clk(clk),
		.rst(rst),
		.grantValid(grantValid),
		.grantCache(grantCache),
		.grantAddr(grantAddr),
		.grantSize(grantSize),
		.wrPending(wrPending),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.memRvalid(memRvalid),
		.memRdata(memRdata),
		.grantTaken(grantTaken),
		.wrPop(wrPop),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memWrite(memWrite),
		.memRead(memRead),
		.readValid(readValid),
		.readData(readData),
		.doneRead(doneRead),
		.doneWrite(doneWrite)
	);

	wordMemory #(
		.READ_LATENCY(READ_LATENCY)
	) memory0 (
		.clk(clk),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memWrite(memWrite),
		.memRead(memRead),
		.memRvalid(memRvalid),
		.memRdata(memRdata)
	);

endmodule : memorySubsystem

// File: design/wordMemory.sv
module wordMemory #(
	parameter int READ_LATENCY = 2
) (
	input  logic clk,
	input  memPkg::memAddr_t memAddr,
	input  memPkg::memData_t memWdata,
	input  logic memWrite,
	input  logic memRead,
	output logic memRvalid,
	output memPkg::memData_t memRdata
);
	import memPkg::*;

	memData_t mem [MEM_WORDS];

	// read return pipeline, stage 0 holds the array output
	logic [READ_LATENCY-1:0] validPipe;
	memData_t dataPipe [READ_LATENCY];

	always_ff @(posedge clk) begin
		if (memWrite) begin
			mem[memAddr] <= memWdata;
		end
	end

	always_ff @(posedge clk) begin
		validPipe[0] <= memRead;
		dataPipe[0] <= mem[memAddr];
		for (int s = 1; s < READ_LATENCY; s++) begin
			validPipe[s] <= validPipe[s-1];
			dataPipe[s] <= dataPipe[s-1];
		end
	end

	// data leaves READ_LATENCY cycles after its address
	assign memRvalid = validPipe[READ_LATENCY-1];
	assign memRdata = dataPipe[READ_LATENCY-1];

endmodule : wordMemory

// File: arbiter/memRequestArbiter.sv
module memRequestArbiter #(
	parameter int NUM_CACHES = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic grantValid,
	input  logic [$clog2(NUM_CACHES)-1:0] grantCache,
	input  memPkg::memAddr_t grantAddr,
	input  memPkg::burstLen_t grantSize,
	input  logic wrPending,
	input  memPkg::memAddr_t wrAddr,
	input  memPkg::memData_t wrData,
	input  logic memRvalid,
	input  memPkg::memData_t memRdata,
	output logic grantTaken,
	output logic wrPop,
	output memPkg::memAddr_t memAddr,
	output memPkg::memData_t memWdata,
	output logic memWrite,
	output logic memRead,
	output logic [NUM_CACHES-1:0] readValid,
	output memPkg::memData_t readData,
	output logic [NUM_CACHES-1:0] doneRead,
	output logic doneWrite
);
	import memPkg::*;

	localparam int IDX_BITS = $clog2(NUM_CACHES);

	seqState_t state;
	seqState_t nextState;

	// latched burst
	logic [IDX_BITS-1:0] curCache;
	memAddr_t nextAddr;
	burstLen_t lastIdx;

	burstLen_t issueCnt;
	burstLen_t retCnt;
	logic wordIn;
	logic lastWord;

	// words only come back while a burst is open
	assign wordIn = memRvalid && (state != IDLE);
	assign lastWord = wordIn && (retCnt == lastIdx);

	always_comb begin
		nextState = state;
		grantTaken = 1'b0;
		wrPop = 1'b0;
		doneWrite = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		memAddr = wrAddr;
		case (state)
			IDLE: begin
				// posted writes go ahead of any waiting burst
				if (wrPending) begin
					memWrite = 1'b1;
					wrPop = 1'b1;
					doneWrite = 1'b1;
				end else if (grantValid) begin
					grantTaken = 1'b1;
					nextState = READ_ISSUE;
				end
			end
			READ_ISSUE: begin
				memRead = 1'b1;
				memAddr = nextAddr;
				if (issueCnt == lastIdx) begin
					nextState = READ_DRAIN;
				end
			end
			READ_DRAIN: begin
				if (lastWord) begin
					nextState = IDLE;
				end
			end
			default: nextState = IDLE;
		endcase
	end

	assign memWdata = wrData;
	assign readData = memRdata;

	// steer the returned word to the owner of the burst
	always_comb begin
		readValid = '0;
		doneRead = '0;
		if (wordIn) begin
			readValid[curCache] = 1'b1;
			doneRead[curCache] = lastWord;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			issueCnt <= '0;
			retCnt <= '0;
		end else begin
			state <= nextState;
			if (grantTaken) begin
				issueCnt <= '0;
				retCnt <= '0;
			end else begin
				if (memRead) begin
					issueCnt <= issueCnt + 1'b1;
				end
				if (wordIn) begin
					retCnt <= retCnt + 1'b1;
				end
			end
		end
	end

	// lastIdx wraps to 63 for a zero size, giving 64 words
	always_ff @(posedge clk) begin
		if (grantTaken) begin
			curCache <= grantCache;
			lastIdx <= grantSize - 1'b1;
			nextAddr <= grantAddr;
		end else if (memRead) begin
			nextAddr <= nextAddr + 1'b1;
		end
	end

endmodule : memRequestArbiter

// File: design/writeBuffer.sv
module writeBuffer #(
	parameter int WRITE_DEPTH = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic writeReq,
	input  memPkg::memAddr_t writeAddr,
	input  memPkg::memData_t writeData,
	input  logic wrPop,
	output logic writeReady,
	output logic wrPending,
	output memPkg::memAddr_t wrAddr,
	output memPkg::memData_t wrData
);
	import memPkg::*;

	localparam int PTR_BITS = (WRITE_DEPTH > 1) ? $clog2(WRITE_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(WRITE_DEPTH + 1);

	memAddr_t addrMem [WRITE_DEPTH];
	memData_t dataMem [WRITE_DEPTH];

	logic [PTR_BITS-1:0] wrPtr;
	logic [PTR_BITS-1:0] rdPtr;
	logic [CNT_BITS-1:0] count;
	logic push;

	assign writeReady = (count != CNT_BITS'(WRITE_DEPTH));
	assign wrPending = (count != '0);
	assign push = writeReq && writeReady;

	// head entry seen by the arbiter
	assign wrAddr = addrMem[rdPtr];
	assign wrData = dataMem[rdPtr];

	always_ff @(posedge clk) begin
		if (push) begin
			addrMem[wrPtr] <= writeAddr;
			dataMem[wrPtr] <= writeData;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == PTR_BITS'(WRITE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (wrPop) begin
				rdPtr <= (rdPtr == PTR_BITS'(WRITE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			case ({push, wrPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule : writeBuffer

// File: design/readSelector.sv
module readSelector #(
	parameter int NUM_CACHES = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic [NUM_CACHES-1:0] readReq,
	input  memPkg::memAddr_t [NUM_CACHES-1:0] readAddr,
	input  memPkg::burstLen_t [NUM_CACHES-1:0] readSize,
	input  logic grantTaken,
	output logic grantValid,
	output logic [$clog2(NUM_CACHES)-1:0] grantCache,
	output memPkg::memAddr_t grantAddr,
	output memPkg::burstLen_t grantSize
);

	localparam int IDX_BITS = $clog2(NUM_CACHES);

	// cache with the highest priority this round
	logic [IDX_BITS-1:0] ptr;

	// scan from the pointer upward, wrapping past the last cache
	always_comb begin
		int cand;
		grantValid = 1'b0;
		grantCache = '0;
		for (int k = 0; k < NUM_CACHES; k++) begin
			cand = int'(ptr) + k;
			if (cand >= NUM_CACHES) begin
				cand = cand - NUM_CACHES;
			end
			if (!grantValid && readReq[cand]) begin
				grantValid = 1'b1;
				grantCache = IDX_BITS'(cand);
			end
		end
	end

	assign grantAddr = readAddr[grantCache];
	assign grantSize = readSize[grantCache];

	// served cache drops to lowest priority
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (grantTaken) begin
			if (grantCache == IDX_BITS'(NUM_CACHES - 1)) begin
				ptr <= '0;
			end else begin
				ptr <= grantCache + 1'b1;
			end
		end
	end

endmodule : readSelector

// File: common/memPkg.sv
package memPkg;

	// word address into the shared memory
	localparam int ADDR_BITS = 10;

	// width of one memory word
	localparam int DATA_BITS = 32;

	// burst word count, zero encodes the largest burst
	localparam int BURST_BITS = 6;

	// number of words behind the address space
	localparam int MEM_WORDS = 1 << ADDR_BITS;

	typedef logic [ADDR_BITS-1:0] memAddr_t;

	typedef logic [DATA_BITS-1:0] memData_t;

	// 0 means 64 words
	typedef logic [BURST_BITS-1:0] burstLen_t;

	// request sequencer
	// writes commit from IDLE without leaving it
	typedef enum logic [1:0] {
		IDLE,
		READ_ISSUE,
		READ_DRAIN
	} seqState_t;

endpackage : memPkg
